//--- src.f
+incdir+include
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_line_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
testbench/burst_ram_model.sv
testbench/dcache_props.sv
testbench/dcache_tb.sv

//--- testbench/dcache_tb.sv
// data cache testbench with clock, reset, burst RAM model and step table
// shadow memory of the RAM preload, immediate checks, watchdog

`timescale 1ns/1ns
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
;

  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DLY = 2;
  localparam int RESET_CYCLES = 4;
  localparam int RAM_WORDS = 512;
  localparam int N_STEPS = 22;
  // one extra access after the second reset
  localparam int WATCHDOG_CYCLES = (N_STEPS + 1) * 40 + 2 * RESET_CYCLES;

  // request plus whether it should miss
  typedef struct packed {
    cache_req_t req;
    logic       miss;
  } step_t;

  logic       clk;
  logic       rst;
  logic       enable;
  cache_req_t req;
  word_t      data_out;
  logic       data_out_ready;
  logic       busy;
  ram_cmd_t   ram_cmd;
  beat_t      ram_wdata;
  beat_t      ram_rdata;
  logic       ram_rvalid;

  word_t shadow [RAM_WORDS];

  // bit 5 picks the line and bits 31:6 form the tag
  step_t steps [N_STEPS] = '{
    '{'{32'h000, 4'b0000, 32'h0000_0000}, 1'b1},  // cold miss on line 0
    '{'{32'h004, 4'b0000, 32'h0000_0000}, 1'b0},
    '{'{32'h01c, 4'b0000, 32'h0000_0000}, 1'b0},
    '{'{32'h008, 4'b0101, 32'ha5a5_5a5a}, 1'b0},  // partial write hit
    '{'{32'h008, 4'b0000, 32'h0000_0000}, 1'b0},
    '{'{32'h040, 4'b0000, 32'h0000_0000}, 1'b1},  // dirty victim written back
    '{'{32'h044, 4'b0000, 32'h0000_0000}, 1'b0},
    '{'{32'h008, 4'b0000, 32'h0000_0000}, 1'b1},  // refill shows the written bytes
    '{'{32'h0a4, 4'b1100, 32'h1234_5678}, 1'b1},  // write miss on cold line 1
    '{'{32'h0a4, 4'b0000, 32'h0000_0000}, 1'b0},
    '{'{32'h0b8, 4'b0000, 32'h0000_0000}, 1'b0},
    '{'{32'h3e0, 4'b1111, 32'hdead_beef}, 1'b1},  // write miss over a dirty line
    '{'{32'h0a4, 4'b0000, 32'h0000_0000}, 1'b1},
    '{'{32'h3e0, 4'b0000, 32'h0000_0000}, 1'b1},
    '{'{32'h000, 4'b0001, 32'h0000_00ff}, 1'b0},
    '{'{32'h7fc, 4'b1000, 32'h7700_0000}, 1'b1},  // write miss over a clean victim
    '{'{32'h7fc, 4'b0000, 32'h0000_0000}, 1'b0},
    '{'{32'h020, 4'b0000, 32'h0000_0000}, 1'b1},
    '{'{32'h7fc, 4'b0000, 32'h0000_0000}, 1'b1},
    '{'{32'h000, 4'b0000, 32'h0000_0000}, 1'b0},
    '{'{32'h600, 4'b0000, 32'h0000_0000}, 1'b1},
    '{'{32'h000, 4'b0000, 32'h0000_0000}, 1'b1}
  };

  dcache_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .req            (req),
    .ram_rdata      (ram_rdata),
    .ram_rvalid     (ram_rvalid),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .ram_cmd        (ram_cmd),
    .ram_wdata      (ram_wdata)
  );

  burst_ram_model #(.READ_DELAY(2)) i_ram (
    .clk    (clk),
    .rst    (rst),
    .cmd    (ram_cmd),
    .wdata  (ram_wdata),
    .rdata  (ram_rdata),
    .rvalid (ram_rvalid)
  );

  bind dcache_top dcache_props i_props (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .req            (req),
    .busy           (busy),
    .data_out_ready (data_out_ready),
    .ram_cmd        (ram_cmd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "testbench stopped at the first error");
  endtask

  // leaves the bench 2 ns after a rising edge with reset released
  task automatic apply_reset();
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    assert (!busy && !data_out_ready)
      else stop_with_failure("busy or data_out_ready high right after reset");
  endtask

  // one request entered and left 2 ns after a rising edge
  task automatic run_step(input step_t s, input int n);
    int    w;
    word_t exp;
    logic  is_read;
    w = s.req.addr[10:2];
    is_read = (s.req.wstrb == '0);
    req = s.req;
    enable = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    enable = 1'b0;
    if (s.miss) begin
      assert (busy)
        else stop_with_failure($sformatf("step %0d should miss but busy stayed low", n));
      // reply comes together with busy falling
      while (busy) begin
        @(posedge clk);
        #DRIVE_DLY;
      end
    end else begin
      assert (!busy)
        else stop_with_failure($sformatf("step %0d should hit but busy went high", n));
    end
    if (is_read) begin
      exp = shadow[w];
      assert (data_out_ready)
        else stop_with_failure($sformatf("no data_out_ready pulse for read step %0d", n));
      assert (data_out == exp)
        else stop_with_failure($sformatf(
          "mismatch at %0t ns: step %0d addr 0x%03h got 0x%08h expected 0x%08h",
          $time, n, s.req.addr, data_out, exp));
    end else begin
      assert (!data_out_ready)
        else stop_with_failure($sformatf("data_out_ready pulsed for write step %0d", n));
      for (int b = 0; b < 4; b++) begin
        if (s.req.wstrb[b]) begin
          shadow[w][8*b +: 8] = s.req.wdata[8*b +: 8];
        end
      end
    end
  endtask

  // bound property failures end the run as well
  always @(negedge clk) begin
    assert (i_dut.i_props.err_cnt == 0)
      else stop_with_failure("a bound property check on the DUT failed");
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_failure("watchdog timeout, the DUT stopped responding");
  end

  initial begin
    rst = 1'b1;
    enable = 1'b0;
    req = '0;
    apply_reset();
    // shadow starts as the RAM preload with word 0 in the low half of a beat
    for (int i = 0; i < RAM_WORDS / 2; i++) begin
      shadow[2*i] = i_ram.mem[i][0];
      shadow[2*i+1] = i_ram.mem[i][1];
    end
    for (int i = 0; i < N_STEPS; i++) begin
      run_step(steps[i], i);
    end
    // reset drops every valid bit so a resident line misses again
    apply_reset();
    run_step('{'{32'h7fc, 4'b0000, 32'h0000_0000}, 1'b1}, N_STEPS);
    if (i_dut.i_props.err_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_with_failure("a bound property check on the DUT failed");
    end
  end

endmodule

`default_nettype wire

//--- testbench/dcache_props.sv
// concurrent checks on the cache top level
// single cycle RAM command, no reply to writes, bounded busy time

`timescale 1ns/1ns
`default_nettype none

module dcache_props
  import dcache_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       enable,
  input cache_req_t req,
  input logic       busy,
  input logic       data_out_ready,
  input ram_cmd_t   ram_cmd
);

  // number of failed assertions, polled by the testbench
  int err_cnt = 0;

  // kind of the request currently being served
  logic last_was_write;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_was_write <= 1'b0;
    end else if (enable && !busy) begin
      last_was_write <= |req.wstrb;
    end
  end

  a_cmd_pulse: assert property (@(posedge clk) disable iff (rst)
    ram_cmd.en |=> !ram_cmd.en)
    else begin
      $error("RAM command enable held longer than one cycle");
      err_cnt++;
    end

  a_no_write_reply: assert property (@(posedge clk) disable iff (rst)
    data_out_ready |-> !last_was_write)
    else begin
      $error("data_out_ready pulsed for a write request");
      err_cnt++;
    end

  // worst case is writeback plus refill with the model's read delay
  a_busy_bounded: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> ##[1:20] !busy)
    else begin
      $error("busy stayed high for more than 20 cycles");
      err_cnt++;
    end

endmodule

`default_nettype wire

//--- testbench/burst_ram_model.sv
// behavioral burst RAM for the cache testbench
// random preload, four beat write bursts, four beat read bursts after a fixed delay

`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module burst_ram_model
  import dcache_pkg::*;
#(
  parameter int READ_DELAY = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  ram_cmd_t cmd,
  input  beat_t    wdata,
  output beat_t    rdata,
  output logic     rvalid
);

  localparam int DEPTH = 1 << `DC_RAM_ADDR_W;

  // beat storage, preloaded once at time zero
  beat_t  mem [DEPTH];
  integer seed;

  // write burst state
  ram_addr_t wr_addr;
  int        wr_left;

  // read burst state
  ram_addr_t rd_addr;
  int        rd_left;
  int        rd_wait;

  initial begin
    seed = 32'hfbb5;
    rdata = '0;
    rvalid = 1'b0;
    for (int a = 0; a < DEPTH; a++) begin
      mem[a][0] = $random(seed);
      mem[a][1] = $random(seed);
    end
  end

  // beat 0 comes with the command and the rest on the following cycles
  always @(posedge clk) begin
    if (rst) begin
      wr_left <= 0;
    end else if (cmd.en && cmd.write) begin
      mem[cmd.addr] <= wdata;
      wr_addr <= cmd.addr + 1'b1;
      wr_left <= `DC_BURST_LEN - 1;
    end else if (wr_left != 0) begin
      mem[wr_addr] <= wdata;
      wr_addr <= wr_addr + 1'b1;
      wr_left <= wr_left - 1;
    end
  end

  // wait READ_DELAY cycles and then stream consecutive beats
  always @(posedge clk) begin
    rvalid <= 1'b0;
    if (rst) begin
      rd_left <= 0;
      rd_wait <= 0;
    end else if (cmd.en && !cmd.write) begin
      rd_addr <= cmd.addr;
      rd_left <= `DC_BURST_LEN;
      rd_wait <= READ_DELAY;
    end else if (rd_left != 0) begin
      if (rd_wait != 0) begin
        rd_wait <= rd_wait - 1;
      end else begin
        rdata <= mem[rd_addr];
        rvalid <= 1'b1;
        rd_addr <= rd_addr + 1'b1;
        rd_left <= rd_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
// data cache top level
// controller, tag store and line store, request address split into fields

`timescale 1ns/1ns
`default_nettype none

module dcache_top
  import dcache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       enable,
  input  cache_req_t req,
  input  beat_t      ram_rdata,
  input  logic       ram_rvalid,
  output word_t      data_out,
  output logic       data_out_ready,
  output logic       busy,
  output ram_cmd_t   ram_cmd,
  output beat_t      ram_wdata
);

  addr_fields_t af;

  // lookup results
  logic hit;
  logic victim_dirty;
  tag_t victim_tag;

  // store controls
  logic     tag_load;
  logic     set_dirty;
  logic     merge_en;
  logic     fill_en;
  beat_ix_t beat_ix;
  word_t    word_rd;

  assign af = req.addr;

  dcache_ctrl i_ctrl (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .req            (req),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .victim_tag     (victim_tag),
    .word_rd        (word_rd),
    .ram_rvalid     (ram_rvalid),
    .busy           (busy),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .ram_cmd        (ram_cmd),
    .tag_load       (tag_load),
    .set_dirty      (set_dirty),
    .merge_en       (merge_en),
    .fill_en        (fill_en),
    .beat_ix        (beat_ix)
  );

  dcache_tag_store i_tag_store (
    .clk          (clk),
    .rst          (rst),
    .line_ix      (af.line_ix),
    .tag          (af.tag),
    .tag_load     (tag_load),
    .set_dirty    (set_dirty),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  // writeback beats go straight to the RAM write data
  dcache_line_store i_line_store (
    .clk       (clk),
    .line_ix   (af.line_ix),
    .word_ix   (af.word_ix),
    .wstrb     (req.wstrb),
    .wdata     (req.wdata),
    .merge_en  (merge_en),
    .fill_en   (fill_en),
    .fill_beat (ram_rdata),
    .beat_ix   (beat_ix),
    .word_rd   (word_rd),
    .beat_rd   (ram_wdata)
  );

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
// miss FSM of the data cache
// hit handling, writeback and refill sequencing, burst counter, RAM commands

`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       enable,
  input  cache_req_t req,
  input  logic       hit,
  input  logic       victim_dirty,
  input  tag_t       victim_tag,
  input  word_t      word_rd,
  input  logic       ram_rvalid,
  output logic       busy,
  output word_t      data_out,
  output logic       data_out_ready,
  output ram_cmd_t   ram_cmd,
  output logic       tag_load,
  output logic       set_dirty,
  output logic       merge_en,
  output logic       fill_en,
  output beat_ix_t   beat_ix
);

  // byte address bits dropped to get a RAM beat address
  localparam int BEAT_SHIFT = $clog2(`DC_BEAT_W / 8);

  localparam beat_ix_t LAST_BEAT = beat_ix_t'(`DC_BURST_LEN - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WRITEBACK,
    S_FILL_WAIT,
    S_FILL,
    S_FINISH
  } state_t;

  state_t       state_q;
  beat_ix_t     beat_cnt_q;
  addr_fields_t af;
  logic         is_write;
  logic         reply;

  assign af = req.addr;
  assign is_write = |req.wstrb;

  // beat address of word 0 of a line
  function automatic ram_addr_t line_ram_addr(tag_t t, line_ix_t l);
    addr_fields_t base;
    base = '{tag: t, line_ix: l, word_ix: '0, byte_ofs: '0};
    return base[BEAT_SHIFT +: `DC_RAM_ADDR_W];
  endfunction

  // same counter steers writeback reads and fill writes
  assign beat_ix = beat_cnt_q;

  // strobes to the stores
  always_comb begin
    tag_load = 1'b0;
    set_dirty = 1'b0;
    merge_en = 1'b0;
    fill_en = 1'b0;
    reply = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (enable) begin
          if (hit) begin
            merge_en = is_write;
            set_dirty = is_write;
            reply = !is_write;
          end else if (!victim_dirty) begin
            // clean victim, take over the line right away
            tag_load = 1'b1;
          end
        end
      end
      S_WRITEBACK: begin
        // old line is out once the last beat leaves
        tag_load = (beat_cnt_q == LAST_BEAT);
      end
      S_FILL_WAIT, S_FILL: begin
        fill_en = ram_rvalid;
      end
      S_FINISH: begin
        // last beat, merge or answer in the same cycle
        fill_en = ram_rvalid;
        merge_en = ram_rvalid && is_write;
        set_dirty = ram_rvalid && is_write;
        reply = ram_rvalid && !is_write;
      end
      default: begin
        fill_en = 1'b0;
      end
    endcase
  end

  // state, busy, command and reply pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      beat_cnt_q <= '0;
      busy <= 1'b0;
      data_out_ready <= 1'b0;
      ram_cmd <= '0;
    end else begin
      // single cycle pulses
      ram_cmd.en <= 1'b0;
      data_out_ready <= reply;
      case (state_q)
        S_IDLE: begin
          if (enable && !hit) begin
            busy <= 1'b1;
            ram_cmd.en <= 1'b1;
            beat_cnt_q <= '0;
            if (victim_dirty) begin
              // evict first, beat 0 goes out with the command
              ram_cmd.write <= 1'b1;
              ram_cmd.addr <= line_ram_addr(victim_tag, af.line_ix);
              state_q <= S_WRITEBACK;
            end else begin
              ram_cmd.write <= 1'b0;
              ram_cmd.addr <= line_ram_addr(af.tag, af.line_ix);
              state_q <= S_FILL_WAIT;
            end
          end
        end
        S_WRITEBACK: begin
          // wraps back to 0 after the last beat
          beat_cnt_q <= beat_cnt_q + 1'b1;
          if (beat_cnt_q == LAST_BEAT) begin
            ram_cmd.en <= 1'b1;
            ram_cmd.write <= 1'b0;
            ram_cmd.addr <= line_ram_addr(af.tag, af.line_ix);
            state_q <= S_FILL_WAIT;
          end
        end
        S_FILL_WAIT: begin
          // RAM latency is open ended
          if (ram_rvalid) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            state_q <= S_FILL;
          end
        end
        S_FILL: begin
          if (ram_rvalid) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (beat_cnt_q == LAST_BEAT - 1'b1) begin
              state_q <= S_FINISH;
            end
          end
        end
        S_FINISH: begin
          if (ram_rvalid) begin
            beat_cnt_q <= '0;
            busy <= 1'b0;
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // reply word, held until the next read
  always_ff @(posedge clk) begin
    if (reply) begin
      data_out <= word_rd;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcache_line_store.sv
// line data array, kept as RAM beats per line
// beat fills, byte merge into one word, word read and writeback beat read

`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache_line_store
  import dcache_pkg::*;
(
  input  logic     clk,
  input  line_ix_t line_ix,
  input  word_ix_t word_ix,
  input  strb_t    wstrb,
  input  word_t    wdata,
  input  logic     merge_en,
  input  logic     fill_en,
  input  beat_t    fill_beat,
  input  beat_ix_t beat_ix,
  output word_t    word_rd,
  output beat_t    beat_rd
);

  // bits of the word index that pick a word inside a beat
  localparam int HALF_W = `DC_WORD_IX_W - `DC_BEAT_IX_W;

  // data, no reset, valid bits live in the tag store
  beat_t data_q [`DC_LINES][`DC_BURST_LEN];

  // where the addressed word sits
  beat_ix_t            word_beat;
  logic [HALF_W-1:0]   word_half;

  assign word_beat = word_ix[`DC_WORD_IX_W-1 -: `DC_BEAT_IX_W];
  assign word_half = word_ix[HALF_W-1:0];

  always_ff @(posedge clk) begin
    // whole beat from the RAM
    if (fill_en) begin
      data_q[line_ix][beat_ix] <= fill_beat;
    end
    // enabled bytes only
    // issued after the fill above so on the last fill beat the merged
    // bytes win and the other bytes take the fresh RAM data
    if (merge_en) begin
      for (int b = 0; b < `DC_STRB_W; b++) begin
        if (wstrb[b]) begin
          data_q[line_ix][word_beat][word_half][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // word read for the requester
  always_comb begin
    word_rd = data_q[line_ix][word_beat][word_half];
    // forward the beat being written this cycle
    // needed when the requested word comes in the last fill beat
    if (fill_en && (beat_ix == word_beat)) begin
      word_rd = fill_beat[word_half];
    end
  end

  // writeback beat, straight onto the RAM write data
  assign beat_rd = data_q[line_ix][beat_ix];

endmodule

`default_nettype wire

//--- rtl/dcache_tag_store.sv
// valid, dirty and tag registers for every cache line
// lookup of the addressed line and tag/dirty updates from the controller

`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache_tag_store
  import dcache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  line_ix_t line_ix,
  input  tag_t     tag,
  input  logic     tag_load,
  input  logic     set_dirty,
  output logic     hit,
  output logic     victim_dirty,
  output tag_t     victim_tag
);

  // one bit per line
  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;

  // tag of whatever currently sits in each line
  tag_t tag_q [`DC_LINES];

  // control bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      // new line arrives clean
      if (tag_load) begin
        valid_q[line_ix] <= 1'b1;
        dirty_q[line_ix] <= 1'b0;
      end
      // a write to a resident line
      if (set_dirty) begin
        dirty_q[line_ix] <= 1'b1;
      end
    end
  end

  // tag array
  always_ff @(posedge clk) begin
    if (tag_load) begin
      tag_q[line_ix] <= tag;
    end
  end

  // lookup is purely combinational so a hit answers in the request cycle
  assign hit = valid_q[line_ix] && (tag_q[line_ix] == tag);

  // an invalid line never needs a writeback
  assign victim_dirty = valid_q[line_ix] && dirty_q[line_ix];

  // old tag builds the writeback address
  assign victim_tag = tag_q[line_ix];

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
// shared cache types: address split, request, RAM command, data words and beats

`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

  // address pieces
  typedef logic [`DC_TAG_W-1:0] tag_t;
  typedef logic [`DC_LINE_IX_W-1:0] line_ix_t;
  typedef logic [`DC_WORD_IX_W-1:0] word_ix_t;
  typedef logic [`DC_BEAT_IX_W-1:0] beat_ix_t;
  typedef logic [`DC_RAM_ADDR_W-1:0] ram_addr_t;

  // payload
  typedef logic [`DC_DATA_W-1:0] word_t;
  typedef logic [`DC_STRB_W-1:0] strb_t;

  // one RAM beat, word 0 in the low half
  typedef logic [`DC_WORDS_PER_BEAT-1:0][`DC_DATA_W-1:0] beat_t;

  // byte address as seen by the cache
  // |tag|line|word|ofs|
  typedef struct packed {
    tag_t                      tag;
    line_ix_t                  line_ix;
    word_ix_t                  word_ix;
    logic [`DC_BYTE_OFS_W-1:0] byte_ofs;
  } addr_fields_t;

  // requester side, wstrb all low means read
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    strb_t                 wstrb;
    word_t                 wdata;
  } cache_req_t;

  // burst command, en is a single cycle pulse
  // addr is the beat address of the first beat of the burst
  typedef struct packed {
    logic      en;
    logic      write;
    ram_addr_t addr;
  } ram_cmd_t;

endpackage

`default_nettype wire

//--- include/dcache_cfg.svh
// cache geometry, word and beat widths, RAM burst shape
// one burst of BURST_LEN beats fills exactly one cache line

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// requester side
`define DC_ADDR_W 32
`define DC_DATA_W 32
`define DC_BYTE_OFS_W 2

// line geometry: 8 words per line, 2 lines
`define DC_WORD_IX_W 3
`define DC_LINE_IX_W 1

// burst RAM: 4 beats of 64 bits, 256 beats deep (2 KB)
`define DC_BEAT_W 64
`define DC_BURST_LEN 4
`define DC_RAM_ADDR_W 8

// derived sizes
`define DC_TAG_W (`DC_ADDR_W - `DC_LINE_IX_W - `DC_WORD_IX_W - `DC_BYTE_OFS_W)
`define DC_BEAT_IX_W ($clog2(`DC_BURST_LEN))
`define DC_LINES (1 << `DC_LINE_IX_W)
`define DC_WORDS_PER_BEAT (`DC_BEAT_W / `DC_DATA_W)
`define DC_STRB_W (`DC_DATA_W / 8)

`endif
